/* design/hwpe_pkg.sv */
/*
 * hwpe shared definitions
 * word and address widths, the register map of the configuration
 * port, the job opcodes and the controller states
 */
package hwpe_pkg;

  // one memory word and one config word have the same width
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // the word count of a job, so a job moves at most 64k-1 words
  localparam int unsigned LEN_WIDTH  = 16;

  // byte offsets inside the engine's config window
  localparam logic [7:0] REG_TRIGGER = 8'h00;
  localparam logic [7:0] REG_STATUS  = 8'h04;
  localparam logic [7:0] REG_SRC     = 8'h08;
  localparam logic [7:0] REG_DST     = 8'h0C;
  localparam logic [7:0] REG_LEN     = 8'h10;
  localparam logic [7:0] REG_OP      = 8'h14;
  localparam logic [7:0] REG_CONST   = 8'h18;
  localparam logic [7:0] REG_CORE    = 8'h1C;

  // the operation applied to each word of a job
  typedef enum logic [1:0] {
    OP_COPY = 2'd0,
    OP_FILL = 2'd1,
    OP_ADD  = 2'd2
  } opcode_e;

  // job phases of the controller
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } ctrl_state_e;

endpackage

/* design/hwpe_cfg_regfile.sv */
/*
 * hwpe configuration registers
 * peripheral slave with single-cycle grant and a registered response,
 * holds the job description and turns trigger writes into start pulses
 */
module hwpe_cfg_regfile #(
  parameter int unsigned N_CORES  = 8,
  parameter int unsigned ID_WIDTH = 8
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               cfg_req_i,
  input  logic [hwpe_pkg::ADDR_WIDTH-1:0]    cfg_add_i,
  input  logic                               cfg_wen_i,
  input  logic [hwpe_pkg::BE_WIDTH-1:0]      cfg_be_i,
  input  logic [hwpe_pkg::DATA_WIDTH-1:0]    cfg_wdata_i,
  input  logic [ID_WIDTH-1:0]                cfg_id_i,
  input  logic                               busy_i,
  output logic                               cfg_gnt_o,
  output logic [hwpe_pkg::DATA_WIDTH-1:0]    cfg_r_rdata_o,
  output logic                               cfg_r_valid_o,
  output logic [ID_WIDTH-1:0]                cfg_r_id_o,
  output logic                               start_o,
  output logic [hwpe_pkg::ADDR_WIDTH-1:0]    src_o,
  output logic [hwpe_pkg::ADDR_WIDTH-1:0]    dst_o,
  output logic [hwpe_pkg::LEN_WIDTH-1:0]     len_o,
  output hwpe_pkg::opcode_e                  op_o,
  output logic [hwpe_pkg::DATA_WIDTH-1:0]    const_o,
  output logic [$clog2(N_CORES)-1:0]         core_o
);

  import hwpe_pkg::*;

  logic [7:0]            offset;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] cur_val;
  logic [DATA_WIDTH-1:0] merged;

  // the slave never stalls, every request is accepted in its own cycle
  assign cfg_gnt_o = cfg_req_i;
  assign offset    = cfg_add_i[7:0];
  assign wr_en     = cfg_req_i & ~cfg_wen_i;

  // a trigger write starts a job, the controller drops it when busy
  assign start_o = wr_en & (offset == REG_TRIGGER);

  // current content of the addressed register, zero extended
  always_comb begin
    case (offset)
      REG_STATUS: cur_val = DATA_WIDTH'(busy_i);
      REG_SRC:    cur_val = DATA_WIDTH'(src_o);
      REG_DST:    cur_val = DATA_WIDTH'(dst_o);
      REG_LEN:    cur_val = DATA_WIDTH'(len_o);
      REG_OP:     cur_val = DATA_WIDTH'(op_o);
      REG_CONST:  cur_val = const_o;
      REG_CORE:   cur_val = DATA_WIDTH'(core_o);
      default:    cur_val = '0;
    endcase
  end

  // bytes without their enable keep the old register content
  always_comb begin
    for (int b = 0; b < BE_WIDTH; b++) begin
      merged[b*8 +: 8] = cfg_be_i[b] ? cfg_wdata_i[b*8 +: 8] : cur_val[b*8 +: 8];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_o   <= '0;
      dst_o   <= '0;
      len_o   <= '0;
      op_o    <= OP_COPY;
      const_o <= '0;
      core_o  <= '0;
    end else if (wr_en) begin
      // fields narrower than a word keep only their low bits
      case (offset)
        REG_SRC:   src_o   <= ADDR_WIDTH'(merged);
        REG_DST:   dst_o   <= ADDR_WIDTH'(merged);
        REG_LEN:   len_o   <= merged[LEN_WIDTH-1:0];
        REG_OP:    op_o    <= opcode_e'(merged[1:0]);
        REG_CONST: const_o <= merged;
        REG_CORE:  core_o  <= merged[$clog2(N_CORES)-1:0];
        default:   ;
      endcase
    end
  end

  // the response follows the grant by one cycle, writes return zero data
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_r_valid_o <= 1'b0;
      cfg_r_id_o    <= '0;
      cfg_r_rdata_o <= '0;
    end else begin
      cfg_r_valid_o <= cfg_gnt_o;
      if (cfg_gnt_o) begin
        cfg_r_id_o    <= cfg_id_i;
        cfg_r_rdata_o <= cfg_wen_i ? cur_val : '0;
      end
    end
  end

  // every response belongs to the request granted in the cycle before,
  // carries its id and returns zero data for a write
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_r_valid_o |-> $past(cfg_gnt_o) && (cfg_r_id_o == $past(cfg_id_i)) &&
    ($past(cfg_wen_i) || (cfg_r_rdata_o == '0)));

endmodule

/* design/hwpe_ctrl.sv */
/*
 * hwpe job controller
 * snapshots the programmed job on start, launches the datamover and
 * raises the done event of the selected core when the job ends
 */
module hwpe_ctrl #(
  parameter int unsigned N_CORES = 8
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               start_i,
  input  logic [hwpe_pkg::ADDR_WIDTH-1:0]    src_i,
  input  logic [hwpe_pkg::ADDR_WIDTH-1:0]    dst_i,
  input  logic [hwpe_pkg::LEN_WIDTH-1:0]     len_i,
  input  hwpe_pkg::opcode_e                  op_i,
  input  logic [hwpe_pkg::DATA_WIDTH-1:0]    const_i,
  input  logic [$clog2(N_CORES)-1:0]         core_i,
  input  logic                               job_done_i,
  output logic                               job_start_o,
  output logic [hwpe_pkg::ADDR_WIDTH-1:0]    job_src_o,
  output logic [hwpe_pkg::ADDR_WIDTH-1:0]    job_dst_o,
  output logic [hwpe_pkg::LEN_WIDTH-1:0]     job_len_o,
  output hwpe_pkg::opcode_e                  job_op_o,
  output logic [hwpe_pkg::DATA_WIDTH-1:0]    job_const_o,
  output logic                               busy_o,
  output logic [N_CORES-1:0]                 evt_o
);

  import hwpe_pkg::*;

  ctrl_state_e                state_q;
  logic [$clog2(N_CORES)-1:0] core_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      job_start_o <= 1'b0;
    end else begin
      // the launch pulse coincides with the first cycle of ST_RUN
      job_start_o <= (state_q == ST_IDLE) & start_i;
      case (state_q)
        ST_IDLE: if (start_i) state_q <= ST_RUN;
        ST_RUN:  if (job_done_i) state_q <= ST_DONE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // job snapshot, so the registers may be reprogrammed while running
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_IDLE) && start_i) begin
      job_src_o   <= src_i;
      job_dst_o   <= dst_i;
      job_len_o   <= len_i;
      job_op_o    <= op_i;
      job_const_o <= const_i;
      core_q      <= core_i;
    end
  end

  assign busy_o = (state_q == ST_RUN);

  // one event cycle on the line of the core latched at start
  assign evt_o = (state_q == ST_DONE) ? (N_CORES'(1) << core_q) : '0;

  // the event sits on one core line and never lasts two cycles in a row
  a_evt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(evt_o) && (($past(evt_o) == '0) || (evt_o == '0)));

endmodule

/* design/hwpe_datamover.sv */
/*
 * hwpe datamover
 * streams a block of words through one tcdm master port, transforming
 * read data into a small response FIFO and writing it back out
 */
module hwpe_datamover #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               job_start_i,
  input  logic [hwpe_pkg::ADDR_WIDTH-1:0]    job_src_i,
  input  logic [hwpe_pkg::ADDR_WIDTH-1:0]    job_dst_i,
  input  logic [hwpe_pkg::LEN_WIDTH-1:0]     job_len_i,
  input  hwpe_pkg::opcode_e                  job_op_i,
  input  logic [hwpe_pkg::DATA_WIDTH-1:0]    job_const_i,
  input  logic                               tcdm_gnt_i,
  input  logic [hwpe_pkg::DATA_WIDTH-1:0]    tcdm_r_data_i,
  input  logic                               tcdm_r_valid_i,
  output logic                               job_done_o,
  output logic                               tcdm_req_o,
  output logic [hwpe_pkg::ADDR_WIDTH-1:0]    tcdm_add_o,
  output logic                               tcdm_wen_o,
  output logic [hwpe_pkg::BE_WIDTH-1:0]      tcdm_be_o,
  output logic [hwpe_pkg::DATA_WIDTH-1:0]    tcdm_data_o
);

  import hwpe_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [ADDR_WIDTH-1:0] rd_addr, wr_addr;
  logic [LEN_WIDTH-1:0]  rd_left, wr_issue_left, wr_left;
  logic [DATA_WIDTH-1:0] fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wptr, rptr;
  logic [CNT_W-1:0]      fifo_cnt, out_cnt;
  logic                  load, wr_cand, rd_cand, do_wr, do_rd, pop, is_fill;

  assign is_fill = (job_op_i == OP_FILL);

  // a new request is chosen when the port is free or the current one is taken
  assign load    = ~tcdm_req_o | tcdm_gnt_i;
  assign wr_cand = is_fill ? (wr_issue_left != '0) : (fifo_cnt != '0);
  // reads need a FIFO slot for every response not yet drained
  assign rd_cand = (rd_left != '0) &&
                   (({1'b0, fifo_cnt} + {1'b0, out_cnt}) < (CNT_W + 1)'(FIFO_DEPTH));
  // waiting output words win over new reads
  assign do_wr   = load & wr_cand;
  assign do_rd   = load & ~wr_cand & rd_cand;
  assign pop     = do_wr & ~is_fill;

  // done on the grant of the last write, or right away for an empty job
  assign job_done_o = (tcdm_req_o & tcdm_gnt_i & ~tcdm_wen_o & (wr_left == LEN_WIDTH'(1))) |
                      (job_start_i & (job_len_i == '0));

  assign tcdm_be_o = '1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_left       <= '0;
      wr_issue_left <= '0;
      wr_left       <= '0;
      tcdm_req_o    <= 1'b0;
      tcdm_wen_o    <= 1'b1;
      wptr          <= '0;
      rptr          <= '0;
      fifo_cnt      <= '0;
      out_cnt       <= '0;
    end else begin
      if (job_start_i) begin
        rd_left       <= is_fill ? '0 : job_len_i;
        wr_issue_left <= job_len_i;
        wr_left       <= job_len_i;
      end else begin
        if (do_rd) rd_left <= rd_left - 1'b1;
        if (do_wr) wr_issue_left <= wr_issue_left - 1'b1;
        if (tcdm_req_o && tcdm_gnt_i && !tcdm_wen_o) wr_left <= wr_left - 1'b1;
      end
      if (load) begin
        tcdm_req_o <= do_wr | do_rd;
        tcdm_wen_o <= ~do_wr;
      end
      // a read is outstanding from issue until its response arrives
      out_cnt  <= out_cnt + CNT_W'(do_rd) - CNT_W'(tcdm_r_valid_i);
      fifo_cnt <= fifo_cnt + CNT_W'(tcdm_r_valid_i) - CNT_W'(pop);
      if (tcdm_r_valid_i) wptr <= (wptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
      if (pop) rptr <= (rptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
    end
  end

  // address counters, request payload and FIFO storage
  always_ff @(posedge clk_i) begin
    if (job_start_i) begin
      rd_addr <= job_src_i;
      wr_addr <= job_dst_i;
    end else begin
      if (do_rd) rd_addr <= rd_addr + ADDR_WIDTH'(BE_WIDTH);
      if (do_wr) wr_addr <= wr_addr + ADDR_WIDTH'(BE_WIDTH);
    end
    if (do_wr) begin
      tcdm_add_o  <= wr_addr;
      tcdm_data_o <= is_fill ? job_const_i : fifo_mem[rptr];
    end else if (do_rd) begin
      tcdm_add_o <= rd_addr;
    end
    // the transform is applied on the way into the FIFO, add wraps mod 2^32
    if (tcdm_r_valid_i) begin
      fifo_mem[wptr] <= (job_op_i == OP_ADD) ? tcdm_r_data_i + job_const_i : tcdm_r_data_i;
    end
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tcdm_req_o && !tcdm_gnt_i |=> tcdm_req_o && $stable(tcdm_add_o) &&
    $stable(tcdm_wen_o) && $stable(tcdm_data_o));

  a_fifo_no_ovf: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tcdm_r_valid_i |-> (fifo_cnt < CNT_W'(FIFO_DEPTH)) && (out_cnt != '0));

endmodule

/* design/hwpe_subsystem.sv */
/*
 * hwpe subsystem top level
 * joins the config slave, the job controller and the datamover, and
 * exposes the tcdm master port and the per-core done events
 */
module hwpe_subsystem #(
  parameter int unsigned N_CORES    = 8,
  parameter int unsigned ID_WIDTH   = 8,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               cfg_req_i,
  input  logic [hwpe_pkg::ADDR_WIDTH-1:0]    cfg_add_i,
  input  logic                               cfg_wen_i,
  input  logic [hwpe_pkg::BE_WIDTH-1:0]      cfg_be_i,
  input  logic [hwpe_pkg::DATA_WIDTH-1:0]    cfg_wdata_i,
  input  logic [ID_WIDTH-1:0]                cfg_id_i,
  output logic                               cfg_gnt_o,
  output logic [hwpe_pkg::DATA_WIDTH-1:0]    cfg_r_rdata_o,
  output logic                               cfg_r_valid_o,
  output logic [ID_WIDTH-1:0]                cfg_r_id_o,
  output logic                               tcdm_req_o,
  output logic [hwpe_pkg::ADDR_WIDTH-1:0]    tcdm_add_o,
  output logic                               tcdm_wen_o,
  output logic [hwpe_pkg::BE_WIDTH-1:0]      tcdm_be_o,
  output logic [hwpe_pkg::DATA_WIDTH-1:0]    tcdm_data_o,
  input  logic                               tcdm_gnt_i,
  input  logic [hwpe_pkg::DATA_WIDTH-1:0]    tcdm_r_data_i,
  input  logic                               tcdm_r_valid_i,
  output logic [N_CORES-1:0]                 evt_o,
  output logic                               busy_o
);

  import hwpe_pkg::*;

  // programmed job, as held by the register block
  logic                       start;
  logic [ADDR_WIDTH-1:0]      src, dst;
  logic [LEN_WIDTH-1:0]       len;
  opcode_e                    op;
  logic [DATA_WIDTH-1:0]      cst;
  logic [$clog2(N_CORES)-1:0] core;

  // running job, as snapshotted by the controller
  logic                       job_start, job_done;
  logic [ADDR_WIDTH-1:0]      job_src, job_dst;
  logic [LEN_WIDTH-1:0]       job_len;
  opcode_e                    job_op;
  logic [DATA_WIDTH-1:0]      job_const;

  hwpe_cfg_regfile #(
    .N_CORES  ( N_CORES  ),
    .ID_WIDTH ( ID_WIDTH )
  ) i_regfile (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .cfg_req_i     ( cfg_req_i     ),
    .cfg_add_i     ( cfg_add_i     ),
    .cfg_wen_i     ( cfg_wen_i     ),
    .cfg_be_i      ( cfg_be_i      ),
    .cfg_wdata_i   ( cfg_wdata_i   ),
    .cfg_id_i      ( cfg_id_i      ),
    .busy_i        ( busy_o        ),
    .cfg_gnt_o     ( cfg_gnt_o     ),
    .cfg_r_rdata_o ( cfg_r_rdata_o ),
    .cfg_r_valid_o ( cfg_r_valid_o ),
    .cfg_r_id_o    ( cfg_r_id_o    ),
    .start_o       ( start         ),
    .src_o         ( src           ),
    .dst_o         ( dst           ),
    .len_o         ( len           ),
    .op_o          ( op            ),
    .const_o       ( cst           ),
    .core_o        ( core          )
  );

  hwpe_ctrl #(
    .N_CORES ( N_CORES )
  ) i_ctrl (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .start_i     ( start     ),
    .src_i       ( src       ),
    .dst_i       ( dst       ),
    .len_i       ( len       ),
    .op_i        ( op        ),
    .const_i     ( cst       ),
    .core_i      ( core      ),
    .job_done_i  ( job_done  ),
    .job_start_o ( job_start ),
    .job_src_o   ( job_src   ),
    .job_dst_o   ( job_dst   ),
    .job_len_o   ( job_len   ),
    .job_op_o    ( job_op    ),
    .job_const_o ( job_const ),
    .busy_o      ( busy_o    ),
    .evt_o       ( evt_o     )
  );

  hwpe_datamover #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_datamover (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .job_start_i    ( job_start      ),
    .job_src_i      ( job_src        ),
    .job_dst_i      ( job_dst        ),
    .job_len_i      ( job_len        ),
    .job_op_i       ( job_op         ),
    .job_const_i    ( job_const      ),
    .tcdm_gnt_i     ( tcdm_gnt_i     ),
    .tcdm_r_data_i  ( tcdm_r_data_i  ),
    .tcdm_r_valid_i ( tcdm_r_valid_i ),
    .job_done_o     ( job_done       ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .tcdm_add_o     ( tcdm_add_o     ),
    .tcdm_wen_o     ( tcdm_wen_o     ),
    .tcdm_be_o      ( tcdm_be_o      ),
    .tcdm_data_o    ( tcdm_data_o    )
  );

endmodule

/* verif/tb_tcdm_mem.sv */
/*
 * behavioral tcdm memory for the hwpe testbench
 * word array with random grant stalls and one-cycle read latency
 */
module tb_tcdm_mem #(
  parameter int unsigned MEM_WORDS = 512
) (
  input  logic                            clk_i,
  input  logic                            tcdm_req_i,
  input  logic [hwpe_pkg::ADDR_WIDTH-1:0] tcdm_add_i,
  input  logic                            tcdm_wen_i,
  input  logic [hwpe_pkg::BE_WIDTH-1:0]   tcdm_be_i,
  input  logic [hwpe_pkg::DATA_WIDTH-1:0] tcdm_data_i,
  output logic                            tcdm_gnt_o,
  output logic [hwpe_pkg::DATA_WIDTH-1:0] tcdm_r_data_o,
  output logic                            tcdm_r_valid_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import hwpe_pkg::*;

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  // the testbench top preloads and inspects this array directly
  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  // transaction accepted in the current cycle, captured mid-cycle
  logic                  acc      = 1'b0;
  logic                  acc_rd   = 1'b0;
  logic [IDX_W-1:0]      acc_idx  = '0;
  logic [BE_WIDTH-1:0]   acc_be   = '0;
  logic [DATA_WIDTH-1:0] acc_data = '0;

  // requests and grants are stable at the falling edge
  always @(negedge clk_i) begin
    acc      = tcdm_req_i && tcdm_gnt_o;
    acc_rd   = tcdm_wen_i;
    acc_idx  = tcdm_add_i[IDX_W+1:2];
    acc_be   = tcdm_be_i;
    acc_data = tcdm_data_i;
  end

  initial begin
    // every word starts with a value tied to its own byte address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[IDX_W'(i)] = 32'hC0DE_0000 ^ (DATA_WIDTH'(i) << 2);
    end
    tcdm_gnt_o     = 1'b0;
    tcdm_r_valid_o = 1'b0;
    tcdm_r_data_o  = '0;
    forever begin
      @(posedge clk_i);
      #1;
      // a write changes only the byte lanes that it enables
      if (acc && !acc_rd) begin
        for (int b = 0; b < BE_WIDTH; b++) begin
          if (acc_be[b]) mem[acc_idx][b*8 +: 8] = acc_data[b*8 +: 8];
        end
      end
      // read data shows up in the cycle after its grant
      tcdm_r_valid_o = acc && acc_rd;
      tcdm_r_data_o  = (acc && acc_rd) ? mem[acc_idx] : '0;
      // about three grants in four cycles, independent of the request
      tcdm_gnt_o = ($urandom % 4) != 0;
    end
  end

endmodule

/* verif/tb_hwpe_subsystem.sv */
/*
 * testbench for the hwpe subsystem
 * programs jobs over the config bus, checks memory against a reference
 * model and watches the per-core done events and the busy flag
 */
module tb_hwpe_subsystem;

  timeunit 1ns;
  timeprecision 1ps;

  import hwpe_pkg::*;

  localparam int unsigned N_CORES    = 8;
  localparam int unsigned ID_WIDTH   = 8;
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned MEM_WORDS  = 512;
  localparam int unsigned IDX_W      = $clog2(MEM_WORDS);
  localparam int          LONG_LEN   = 48;
  // 64 cycles of slack plus 8 cycles for each word of the four real jobs
  localparam int          WATCHDOG_CYCLES = 64 + 8 * (16 + 16 + 16 + LONG_LEN);

  logic clk = 1'b0;
  logic rst_n;
  logic                  cfg_req, cfg_wen, cfg_gnt, cfg_r_valid;
  logic [ADDR_WIDTH-1:0] cfg_add;
  logic [BE_WIDTH-1:0]   cfg_be;
  logic [DATA_WIDTH-1:0] cfg_wdata, cfg_r_rdata;
  logic [ID_WIDTH-1:0]   cfg_id, cfg_r_id, next_id;
  logic                  tcdm_req, tcdm_wen, tcdm_gnt, tcdm_r_valid;
  logic [ADDR_WIDTH-1:0] tcdm_add;
  logic [BE_WIDTH-1:0]   tcdm_be;
  logic [DATA_WIDTH-1:0] tcdm_data, tcdm_r_data;
  logic [N_CORES-1:0]    evt, exp_evt;
  logic                  busy;

  // memory image taken before each job, and the job being checked
  logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
  int                    job_src, job_dst, job_len, evt_before;
  int                    evt_seen = 0;
  opcode_e               job_op;
  logic [DATA_WIDTH-1:0] job_cst;

  always #4 clk = ~clk;

  hwpe_subsystem #(
    .N_CORES    ( N_CORES    ),
    .ID_WIDTH   ( ID_WIDTH   ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) UUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .cfg_req_i (cfg_req), .cfg_add_i (cfg_add), .cfg_wen_i (cfg_wen), .cfg_be_i (cfg_be),
    .cfg_wdata_i (cfg_wdata), .cfg_id_i (cfg_id), .cfg_gnt_o (cfg_gnt),
    .cfg_r_rdata_o (cfg_r_rdata), .cfg_r_valid_o (cfg_r_valid), .cfg_r_id_o (cfg_r_id),
    .tcdm_req_o (tcdm_req), .tcdm_add_o (tcdm_add), .tcdm_wen_o (tcdm_wen),
    .tcdm_be_o (tcdm_be), .tcdm_data_o (tcdm_data), .tcdm_gnt_i (tcdm_gnt),
    .tcdm_r_data_i (tcdm_r_data), .tcdm_r_valid_i (tcdm_r_valid),
    .evt_o (evt), .busy_o (busy)
  );

  tb_tcdm_mem #(
    .MEM_WORDS ( MEM_WORDS )
  ) mem_model (
    .clk_i (clk), .tcdm_req_i (tcdm_req), .tcdm_add_i (tcdm_add), .tcdm_wen_i (tcdm_wen),
    .tcdm_be_i (tcdm_be), .tcdm_data_i (tcdm_data), .tcdm_gnt_o (tcdm_gnt),
    .tcdm_r_data_o (tcdm_r_data), .tcdm_r_valid_o (tcdm_r_valid)
  );

  // destination word as the operation defines it, add wraps at 2^32
  function automatic logic [DATA_WIDTH-1:0] expected_word(input opcode_e op,
      input logic [DATA_WIDTH-1:0] src, input logic [DATA_WIDTH-1:0] cst);
    case (op)
      OP_FILL: return cst;
      OP_ADD:  return src + cst;
      default: return src;
    endcase
  endfunction

  function automatic logic [DATA_WIDTH-1:0] mem_peek(input int idx);
    return mem_model.mem[IDX_W'(idx)];
  endfunction

  task automatic mem_poke(input int idx, input logic [DATA_WIDTH-1:0] val);
    mem_model.mem[IDX_W'(idx)] = val;
  endtask

  task automatic check_word(input logic [DATA_WIDTH-1:0] got,
      input logic [DATA_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_evt(input logic [N_CORES-1:0] got, input logic [N_CORES-1:0] exp,
      input string what);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // one config transaction, called 1 ns after a rising edge
  task automatic cfg_access(input logic wen, input logic [7:0] off,
      input logic [DATA_WIDTH-1:0] wdata, output logic [DATA_WIDTH-1:0] rdata);
    logic [ID_WIDTH-1:0] id;
    id        = next_id;
    next_id   = next_id + ID_WIDTH'(1);
    cfg_req   = 1'b1;
    cfg_add   = ADDR_WIDTH'(off);
    cfg_wen   = wen;
    cfg_wdata = wdata;
    cfg_id    = id;
    @(negedge clk);
    check_word(DATA_WIDTH'(cfg_gnt), 1, "config grant");
    @(posedge clk);
    #1;
    cfg_req = 1'b0;
    while (!cfg_r_valid) begin
      @(posedge clk);
      #1;
    end
    check_word(DATA_WIDTH'(cfg_r_id), DATA_WIDTH'(id), "config response id");
    rdata = cfg_r_rdata;
  endtask

  task automatic cfg_write(input logic [7:0] off, input logic [DATA_WIDTH-1:0] wdata);
    logic [DATA_WIDTH-1:0] rdata;
    cfg_access(1'b0, off, wdata, rdata);
    check_word(rdata, 0, "write response data");
  endtask

  task automatic cfg_read(input logic [7:0] off, output logic [DATA_WIDTH-1:0] rdata);
    cfg_access(1'b1, off, '0, rdata);
  endtask

  // snapshot memory, program the job and trigger it
  task automatic start_job(input int src_w, input int dst_w, input int len, input opcode_e op,
      input logic [DATA_WIDTH-1:0] cst, input int core);
    for (int i = 0; i < MEM_WORDS; i++) ref_mem[IDX_W'(i)] = mem_peek(i);
    job_src = src_w;
    job_dst = dst_w;
    job_len = len;
    job_op  = op;
    job_cst = cst;
    exp_evt = N_CORES'(1) << core;
    cfg_write(REG_SRC, DATA_WIDTH'(src_w * 4));
    cfg_write(REG_DST, DATA_WIDTH'(dst_w * 4));
    cfg_write(REG_LEN, DATA_WIDTH'(len));
    cfg_write(REG_OP, DATA_WIDTH'(op));
    cfg_write(REG_CONST, cst);
    cfg_write(REG_CORE, DATA_WIDTH'(core));
    evt_before = evt_seen;
    cfg_write(REG_TRIGGER, '0);
  endtask

  // wait for the done event, then compare the whole memory image
  task automatic finish_job();
    int                    cycles;
    logic [DATA_WIDTH-1:0] exp;
    cycles = 0;
    check_word(DATA_WIDTH'(busy), 1, "busy while the job runs");
    while (evt == '0) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    // an empty job ends two cycles after the trigger grant
    if (job_len == 0) check_word(DATA_WIDTH'(cycles), 1, "zero length event delay");
    repeat (2) begin
      @(posedge clk);
      #1;
    end
    check_word(DATA_WIDTH'(evt_seen - evt_before), 1, "event pulses per job");
    check_word(DATA_WIDTH'(busy), 0, "busy after the job");
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (i >= job_dst && i < job_dst + job_len) begin
        exp = expected_word(job_op, ref_mem[IDX_W'(i - job_dst + job_src)], job_cst);
      end else begin
        exp = ref_mem[IDX_W'(i)];
      end
      check_word(mem_peek(i), exp, $sformatf("memory word %0d", i));
    end
  endtask

  // every event cycle must hit only the programmed core and drop busy
  always @(negedge clk) begin
    if (rst_n && (evt != '0)) begin
      check_evt(evt, exp_evt, "done event lines");
      check_word(DATA_WIDTH'(busy), 0, "busy in the event cycle");
      evt_seen++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the engine hung", WATCHDOG_CYCLES);
    $display("Checks failed");
    $fatal(1, "simulation stopped by the watchdog");
  end

  initial begin
    logic [DATA_WIDTH-1:0] rd;
    logic [7:0]            offs [6];
    logic [DATA_WIDTH-1:0] vals [6];
    void'($urandom(98552));
    rst_n     = 1'b0;
    cfg_req   = 1'b0;
    cfg_add   = '0;
    cfg_wen   = 1'b1;
    cfg_be    = '1;
    cfg_wdata = '0;
    cfg_id    = '0;
    next_id   = 8'h40;
    exp_evt   = '0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;

    // register readback with distinct ids on every access
    offs = '{REG_SRC, REG_DST, REG_LEN, REG_OP, REG_CONST, REG_CORE};
    vals = '{32'h1234_5678, 32'h9ABC_DEF0, 32'h0000_BEEF, 32'h2, 32'hCAFE_F00D, 32'h6};
    for (int k = 0; k < 6; k++) cfg_write(offs[k], vals[k]);
    for (int k = 0; k < 6; k++) begin
      cfg_read(offs[k], rd);
      check_word(rd, vals[k], $sformatf("readback of offset %h", offs[k]));
    end

    // copy of random words
    for (int k = 0; k < 16; k++) mem_poke(16 + k, $urandom);
    start_job(16, 64, 16, OP_COPY, 32'h0, 3);
    finish_job();

    // fill needs no source, add sources sit near the top so every sum wraps
    start_job(0, 100, 16, OP_FILL, $urandom, 1);
    finish_job();
    for (int k = 0; k < 16; k++) mem_poke(130 + k, 32'hFFFF_F000 | ($urandom & 32'h0FFF));
    start_job(130, 160, 16, OP_ADD, 32'h8000_1000 | ($urandom & 32'h0FFF), 0);
    finish_job();

    // long job, reprogrammed and retriggered while it runs
    for (int k = 0; k < LONG_LEN; k++) mem_poke(256 + k, $urandom);
    start_job(256, 320, LONG_LEN, OP_COPY, 32'h0, 5);
    cfg_read(REG_STATUS, rd);
    check_word(rd, 1, "status during a long job");
    cfg_write(REG_DST, DATA_WIDTH'(400 * 4));
    cfg_write(REG_OP, DATA_WIDTH'(OP_FILL));
    cfg_write(REG_CORE, 2);
    cfg_write(REG_TRIGGER, '0);
    finish_job();
    cfg_read(REG_STATUS, rd);
    check_word(rd, 0, "status after the long job");

    // empty job leaves memory alone
    start_job(16, 64, 0, OP_FILL, 32'hFFFF_FFFF, 7);
    finish_job();

    $display("All checks passed");
    $finish;
  end

endmodule

/* tb.f */
design/hwpe_pkg.sv
design/hwpe_cfg_regfile.sv
design/hwpe_ctrl.sv
design/hwpe_datamover.sv
design/hwpe_subsystem.sv
verif/tb_tcdm_mem.sv
verif/tb_hwpe_subsystem.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      ?= tb_hwpe_subsystem
FILELIST ?= tb.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
FAIL_MSG  = Checks failed
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
